// ==== verilog/lib_arbiter_pkg.sv ====
// Grid arbiter shared definitions
// Default grid sizes, the grant struct sent to the requesters
// and the state encoding of the row arbiter

package lib_arbiter_pkg;

    // Default grid size, four rows by four columns
    parameter int LVL_ROWS    = 4;             // Number of requester rows
    parameter int LVL_COLS    = 4;             // Number of requester columns
    parameter int LVL_ROW_ADD = 2;             // Row address width
    parameter int LVL_COL_ADD = 2;             // Column address width

    // One grant notice, valid for a single cycle
    typedef struct packed
    {
        logic                   valid;         // Grant present this cycle
        logic [LVL_ROW_ADD-1:0] row;           // Granted row
        logic [LVL_COL_ADD-1:0] col;           // Granted column
    } grant_t;

    // Row arbiter states
    typedef enum logic [1:0]
    {
        ROW_IDLE    = 2'b00,                   // Choosing a row
        ROW_LOCK    = 2'b01,                   // Row locked, columns being granted
        ROW_RELEASE = 2'b10                    // Gap for mask reset and pointer step
    } row_state_e;

endpackage

// ==== verilog/priority_arb.sv ====
// Fixed priority arbiter
// Passes only the lowest index request bit, purely combinational

module priority_arb
#(
    parameter int LVL_ROWS = 4                      // Width of the request vector
)
(
    input  logic [LVL_ROWS-1:0] req_i,              // Request vector
    output logic [LVL_ROWS-1:0] gnt_o               // One-hot grant, zero if no request
);

    logic found;                                    // Lower index already granted

    always_comb
    begin
        gnt_o = '0;
        found = 1'b0;
        // Scan upward, first set bit wins
        for (int i = 0; i < LVL_ROWS; i++)
        begin
            if (req_i[i] && !found)
            begin
                gnt_o[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/request_latch.sv ====
// Request latch
// Holds one pending bit per requester of the grid. A request pulse
// sets the bit, a valid grant naming the requester clears it.
// A set and a clear on the same bit in one cycle leave it set

module request_latch
    import lib_arbiter_pkg::*;
#(
    parameter int LVL_ROWS = lib_arbiter_pkg::LVL_ROWS,   // Grid rows
    parameter int LVL_COLS = lib_arbiter_pkg::LVL_COLS    // Grid columns
)
(
    input  logic                         clk_i,           // System clock
    input  logic                         reset_i,         // Async reset, active high
    input  logic [LVL_ROWS*LVL_COLS-1:0] req_i,           // Request pulses, row major
    input  grant_t                       grant_i,         // Grant fed back as clear
    output logic [LVL_ROWS*LVL_COLS-1:0] pending_o        // Pending matrix
);

    logic [LVL_ROWS*LVL_COLS-1:0] pending_q;              // Pending bits
    logic [LVL_ROWS*LVL_COLS-1:0] clr_vec;                // One-hot clear from grant

    // Decode the granted requester into its bit position
    always_comb
    begin
        clr_vec = '0;
        if (grant_i.valid)
        begin
            // Bit index is row times column count plus column
            clr_vec[grant_i.row * LVL_COLS + grant_i.col] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pending_q <= '0;                              // Nothing pending after reset
        end
        else
        begin
            // Clear first, then OR in new pulses so the set wins
            pending_q <= (pending_q & ~clr_vec) | req_i;
        end
    end

    assign pending_o = pending_q;

endmodule

// ==== verilog/column_arbiter.sv ====
// Column arbiter
// Grants the pending columns of the locked row one per cycle in
// rising order. A mask register moves above each granted column,
// the grant is registered and encoded into a column address.
// Group release flags a cycle with no masked request left

module column_arbiter
#(
    parameter int LVL_COLS    = 4,                  // Columns per row
    parameter int LVL_COL_ADD = 2                   // Column address width
)
(
    input  logic                   clk_i,           // System clock
    input  logic                   reset_i,         // Async reset, active high
    input  logic                   enable_i,        // High while a row is locked
    input  logic [LVL_COLS-1:0]    req_i,           // Pending columns of the row
    output logic [LVL_COLS-1:0]    gnt_o,           // Registered one-hot grant
    output logic [LVL_COL_ADD-1:0] yadd_o,          // Encoded column of gnt_o
    output logic                   grp_release_o    // No masked request last cycle
);

    logic [LVL_COLS-1:0] mask_q;                    // Columns still allowed this pass
    logic [LVL_COLS-1:0] mask_d;                    // Mask after this cycle's grant
    logic [LVL_COLS-1:0] mask_req;                  // Requests that pass the mask
    logic [LVL_COLS-1:0] gnt_next;                  // Grant chosen this cycle

    assign mask_req = req_i & mask_q;

    // Lowest masked column wins
    priority_arb #(
        .LVL_ROWS (LVL_COLS)
    ) u_prio (
        .req_i (mask_req),
        .gnt_o (gnt_next)
    );

    // Move the mask just above the chosen column
    always_comb
    begin
        mask_d = mask_q;                            // Hold when nothing is chosen
        for (int i = 0; i < LVL_COLS; i++)
        begin
            if (gnt_next[i])
            begin
                mask_d = {LVL_COLS{1'b1}} << (i + 1);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q <= {LVL_COLS{1'b1}};
            gnt_o  <= '0;
        end
        else if (enable_i)
        begin
            mask_q <= mask_d;
            gnt_o  <= gnt_next;                     // Grant shows one cycle after choice
        end
        else
        begin
            // Idle row, open the mask for the next pass
            mask_q <= {LVL_COLS{1'b1}};
            gnt_o  <= '0;
        end
    end

    // Tracks the masked request even while disabled, so the
    // row arbiter sees a clear flag on the first locked cycle
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            grp_release_o <= 1'b0;
        else
            grp_release_o <= (gnt_next == '0);
    end

    // One-hot to binary column address
    function automatic logic [LVL_COL_ADD-1:0] encode_col(input logic [LVL_COLS-1:0] onehot);
        logic [LVL_COL_ADD-1:0] idx;
        idx = '0;
        for (int i = 0; i < LVL_COLS; i++)
        begin
            if (onehot[i])
                idx = LVL_COL_ADD'(i);
        end
        return idx;
    endfunction

    assign yadd_o = encode_col(gnt_o);              // Zero when no grant

endmodule

// ==== verilog/row_arbiter.sv ====
// Row arbiter
// Round-robin choice of the next row with pending requests, starting
// after the last served row. Locks the row, enables the column
// arbiter and builds the grant notice from its column grant.
// A release state resets the column mask and steps the pointer

module row_arbiter
    import lib_arbiter_pkg::*;
#(
    parameter int LVL_ROWS    = lib_arbiter_pkg::LVL_ROWS,     // Grid rows
    parameter int LVL_COLS    = lib_arbiter_pkg::LVL_COLS,     // Grid columns
    parameter int LVL_ROW_ADD = lib_arbiter_pkg::LVL_ROW_ADD,  // Row address width
    parameter int LVL_COL_ADD = lib_arbiter_pkg::LVL_COL_ADD   // Column address width
)
(
    input  logic                         clk_i,                // System clock
    input  logic                         reset_i,              // Async reset, active high
    input  logic [LVL_ROWS*LVL_COLS-1:0] pending_i,            // Pending matrix
    input  logic [LVL_COLS-1:0]          col_gnt_i,            // Column grant, one-hot
    input  logic [LVL_COL_ADD-1:0]       col_add_i,            // Encoded column grant
    input  logic                         col_release_i,        // Column group done
    output logic [LVL_COLS-1:0]          row_req_o,            // Pending bits of the row
    output logic                         col_enable_o,         // Column arbiter enable
    output grant_t                       grant_o,              // Grant notice
    output logic                         busy_o                // Work in progress
);

    row_state_e             state_q;
    row_state_e             state_d;
    logic [LVL_ROW_ADD-1:0] lock_row_q;          // Row being served
    logic [LVL_ROW_ADD-1:0] last_row_q;          // Last served row, round-robin pointer
    logic [LVL_ROW_ADD-1:0] next_row;            // First pending row after the pointer
    logic                   row_found;           // Some row has pending bits
    logic [LVL_ROW_ADD-1:0] sel_row;             // Row forwarded to the column arbiter

    // Search rows after the pointer, wrapping around
    always_comb
    begin : find_row
        int cand;
        row_found = 1'b0;
        next_row  = '0;
        for (int i = 1; i <= LVL_ROWS; i++)
        begin
            cand = (int'(last_row_q) + i) % LVL_ROWS;
            if (!row_found && (|pending_i[cand*LVL_COLS +: LVL_COLS]))
            begin
                row_found = 1'b1;
                next_row  = LVL_ROW_ADD'(cand);
            end
        end
    end

    // In idle the candidate row is shown early, which keeps the
    // group release low on the first locked cycle
    assign sel_row   = (state_q == ROW_IDLE) ? next_row : lock_row_q;
    assign row_req_o = pending_i[sel_row*LVL_COLS +: LVL_COLS];

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ROW_IDLE:
            begin
                if (row_found)
                    state_d = ROW_LOCK;
            end
            ROW_LOCK:
            begin
                // Done once the mask is empty and the last grant has gone
                if (col_release_i && (col_gnt_i == '0))
                    state_d = ROW_RELEASE;
            end
            ROW_RELEASE:
                state_d = ROW_IDLE;                // Single gap cycle
            default:
                state_d = ROW_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q    <= ROW_IDLE;
            lock_row_q <= '0;
            last_row_q <= LVL_ROW_ADD'(LVL_ROWS - 1);   // Row 0 comes first
        end
        else
        begin
            state_q <= state_d;
            if ((state_q == ROW_IDLE) && row_found)
                lock_row_q <= next_row;                // Lock the chosen row
            if (state_q == ROW_RELEASE)
                last_row_q <= lock_row_q;              // Advance round-robin pointer
        end
    end

    assign col_enable_o = (state_q == ROW_LOCK);

    // Grant notice from the registered column grant
    assign grant_o.valid = |col_gnt_i;
    assign grant_o.row   = lock_row_q;
    assign grant_o.col   = col_add_i;

    assign busy_o = (state_q != ROW_IDLE) || (|pending_i);

endmodule

// ==== verilog/grid_arbiter.sv ====
// Grid arbiter top level
// Two-level request/grant arbiter for a grid of requesters. The
// request latch buffers pulses, the row arbiter picks a row in
// round-robin order and the column arbiter grants its columns

module grid_arbiter
    import lib_arbiter_pkg::*;
#(
    parameter int LVL_ROWS    = lib_arbiter_pkg::LVL_ROWS,     // Grid rows
    parameter int LVL_COLS    = lib_arbiter_pkg::LVL_COLS,     // Grid columns
    parameter int LVL_ROW_ADD = lib_arbiter_pkg::LVL_ROW_ADD,  // Row address width
    parameter int LVL_COL_ADD = lib_arbiter_pkg::LVL_COL_ADD   // Column address width
)
(
    input  logic                         clk_i,                // System clock
    input  logic                         reset_i,              // Async reset, active high
    input  logic [LVL_ROWS*LVL_COLS-1:0] req_i,                // Request pulses, row major
    output grant_t                       grant_o,              // One-cycle grant notice
    output logic                         busy_o                // Pending or serving
);

    logic [LVL_ROWS*LVL_COLS-1:0] pending;       // Latched requests
    logic [LVL_COLS-1:0]          row_req;       // Locked row to column arbiter
    logic                         col_enable;    // Column arbiter enable
    logic [LVL_COLS-1:0]          col_gnt;       // Registered column grant
    logic [LVL_COL_ADD-1:0]       col_add;       // Encoded column
    logic                         col_release;   // Column group done

    // Grant output doubles as the clear for the latch
    request_latch #(
        .LVL_ROWS (LVL_ROWS),
        .LVL_COLS (LVL_COLS)
    ) u_latch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .grant_i   (grant_o),
        .pending_o (pending)
    );

    row_arbiter #(
        .LVL_ROWS    (LVL_ROWS),
        .LVL_COLS    (LVL_COLS),
        .LVL_ROW_ADD (LVL_ROW_ADD),
        .LVL_COL_ADD (LVL_COL_ADD)
    ) u_row (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pending_i     (pending),
        .col_gnt_i     (col_gnt),
        .col_add_i     (col_add),
        .col_release_i (col_release),
        .row_req_o     (row_req),
        .col_enable_o  (col_enable),
        .grant_o       (grant_o),
        .busy_o        (busy_o)
    );

    column_arbiter #(
        .LVL_COLS    (LVL_COLS),
        .LVL_COL_ADD (LVL_COL_ADD)
    ) u_col (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (col_enable),
        .req_i         (row_req),
        .gnt_o         (col_gnt),
        .yadd_o        (col_add),
        .grp_release_o (col_release)
    );

endmodule

// ==== testbench/grid_arbiter_assert.sv ====
// Grid arbiter assertions
// Bound into the top level. Checks the grant output against the
// pending matrix, the column enable and the row lock

module grid_arbiter_assert
    import lib_arbiter_pkg::*;
#(
    parameter int LVL_ROWS    = lib_arbiter_pkg::LVL_ROWS,     // Grid rows
    parameter int LVL_COLS    = lib_arbiter_pkg::LVL_COLS,     // Grid columns
    parameter int LVL_ROW_ADD = lib_arbiter_pkg::LVL_ROW_ADD   // Row address width
)
(
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  grant_t                       grant_i,              // Grant notice
    input  logic [LVL_ROWS*LVL_COLS-1:0] pending_i,            // Latched requests
    input  logic                         col_enable_i,         // Column arbiter enable
    input  row_state_e                   state_i,              // Row arbiter state
    input  logic [LVL_ROW_ADD-1:0]       lock_row_i            // Locked row
);
    timeunit 1ns;
    timeprecision 100ps;

    // No grant while reset is held
    grant_in_reset: assert property (@(posedge clk_i) reset_i |-> !grant_i.valid)
        else $error("Grant seen during reset");

    // Granted requester must still be pending
    grant_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        grant_i.valid |-> pending_i[grant_i.row * LVL_COLS + grant_i.col])
        else $error("Grant to a requester with no pending bit");

    // Column arbiter stays silent the cycle after its enable is low
    grant_needs_enable: assert property (@(posedge clk_i) disable iff (reset_i)
        !col_enable_i |=> !grant_i.valid)
        else $error("Grant without a column enable in the previous cycle");

    lock_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_i == ROW_LOCK) ##1 (state_i == ROW_LOCK) |-> $stable(lock_row_i))
        else $error("Locked row changed during a pass");

endmodule

bind grid_arbiter grid_arbiter_assert #(
    .LVL_ROWS    (LVL_ROWS),
    .LVL_COLS    (LVL_COLS),
    .LVL_ROW_ADD (LVL_ROW_ADD)
) u_assert (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .grant_i      (grant_o),
    .pending_i    (pending),
    .col_enable_i (col_enable),
    .state_i      (u_row.state_q),
    .lock_row_i   (u_row.lock_row_q)
);

// ==== testbench/grid_arbiter_tb.sv ====
// Grid arbiter testbench
// Applies a table of request matrices, predicts the grant order
// with a round-robin reference model and checks every grant

module grid_arbiter_tb
    import lib_arbiter_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NREQ    = LVL_ROWS * LVL_COLS;
    localparam int NTEST   = 26;                       // Six directed plus twenty random
    localparam int TIMEOUT = 16 * NTEST * LVL_ROWS * LVL_COLS;

    logic            clk_i;
    logic            reset_i;
    logic [NREQ-1:0] req_i;
    grant_t          grant_o;
    logic            busy_o;

    // Stimulus table
    string           tab_name  [NTEST];
    logic [NREQ-1:0] tab_req   [NTEST];
    bit              tab_mid   [NTEST];                // Applied during a pass
    bit              tab_burst [NTEST];                // Grants must be back to back

    // Reference model state
    logic [NREQ-1:0] model_pend;
    bit              locked;
    int              lock_row;
    int              last_row = LVL_ROWS - 1;          // Row 0 served first
    int              last_col;
    int              pulse_cnt [NREQ];
    int              grant_cnt [NREQ];

    string           cur_test = "reset";
    bit              cur_burst;
    int              last_gnt_cyc = -1;
    int              cycles;
    int              checks;
    int              errors;
    logic [31:0]     lfsr = 32'h6212;

    grid_arbiter #(
        .LVL_ROWS    (LVL_ROWS),
        .LVL_COLS    (LVL_COLS),
        .LVL_ROW_ADD (LVL_ROW_ADD),
        .LVL_COL_ADD (LVL_COL_ADD)
    ) dut0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req_i),
        .grant_o (grant_o),
        .busy_o  (busy_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                     // 4 ns period
    end

    task automatic check(input string what, input int exp, input int act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic set_entry(input int t, input string name, input logic [NREQ-1:0] req,
                             input bit mid, input bit burst);
        tab_name[t]  = name;
        tab_req[t]   = req;
        tab_mid[t]   = mid;
        tab_burst[t] = burst;
    endtask

    task automatic build_table();
        logic [NREQ-1:0] pat;
        set_entry(0, "single_req", 16'h0200, 1'b0, 1'b0);   // Row 2 col 1
        set_entry(1, "full_row", 16'hF000, 1'b0, 1'b1);     // All of row 3
        set_entry(2, "rr_seed", 16'h0020, 1'b0, 1'b0);      // Leaves pointer at row 1
        set_entry(3, "multi_row", 16'h4C05, 1'b0, 1'b0);    // Rows 0, 2 and 3
        set_entry(4, "inject_base", 16'h0060, 1'b0, 1'b0);  // Row 1 cols 1 and 2
        set_entry(5, "inject_mid", 16'h0090, 1'b1, 1'b0);   // Col 3 above mask, col 0 below
        for (int t = 6; t < NTEST; t++)
        begin
            for (int b = 0; b < NREQ; b++)
            begin
                lfsr   = lfsr_step(lfsr);
                pat[b] = lfsr[0];
            end
            set_entry(t, $sformatf("random_%0d", t - 5), pat, 1'b0, 1'b0);
        end
    endtask

    // End the current pass, pointer moves to the served row
    task automatic close_pass();
        if (locked)
        begin
            last_row = lock_row;
            locked   = 1'b0;
        end
    endtask

    task automatic add_pulses(input logic [NREQ-1:0] req);
        for (int i = 0; i < NREQ; i++)
        begin
            if (req[i])
            begin
                model_pend[i] = 1'b1;
                pulse_cnt[i]++;
            end
        end
    endtask

    // Next grant: higher column in the locked row, else next pending row
    task automatic predict_grant(output int row, output int col, output bit ok);
        int r;
        ok  = 1'b0;
        row = 0;
        col = 0;
        if (locked)
        begin
            for (int c = last_col + 1; c < LVL_COLS; c++)
            begin
                if (!ok && model_pend[lock_row * LVL_COLS + c])
                begin
                    ok  = 1'b1;
                    row = lock_row;
                    col = c;
                end
            end
            if (!ok)
                close_pass();
        end
        for (int i = 1; i <= LVL_ROWS; i++)
        begin
            r = (last_row + i) % LVL_ROWS;
            for (int c = 0; c < LVL_COLS; c++)
            begin
                if (!ok && model_pend[r * LVL_COLS + c])
                begin
                    ok       = 1'b1;
                    row      = r;
                    col      = c;
                    locked   = 1'b1;
                    lock_row = r;
                end
            end
        end
        if (ok)
            last_col = col;
    endtask

    // Wait until nothing is pending and the row arbiter is idle
    task automatic wait_idle();
        do
            @(negedge clk_i);
        while (busy_o);
        check("left pending", 0, int'(model_pend));
    endtask

    task automatic run_entry(input int t);
        if (tab_mid[t])
        begin
            do
                @(negedge clk_i);
            while (!grant_o.valid);                    // First grant of the running pass
        end
        else
        begin
            wait_idle();
            close_pass();
        end
        @(posedge clk_i);
        cur_test     = tab_name[t];
        cur_burst    = tab_burst[t];
        last_gnt_cyc = -1;
        req_i       <= tab_req[t];                     // One-cycle pulse
        add_pulses(tab_req[t]);
        @(posedge clk_i);
        req_i <= '0;
        @(negedge clk_i);
        check("busy after pulse", 1, int'(busy_o));    // Latched pulse keeps it busy
    endtask

    always @(negedge clk_i)
    begin : grant_monitor
        int exp_row;
        int exp_col;
        bit found;
        if (!reset_i && grant_o.valid)
        begin
            grant_cnt[int'(grant_o.row) * LVL_COLS + int'(grant_o.col)]++;
            predict_grant(exp_row, exp_col, found);
            if (!found)
            begin
                errors++;
                $display("Error in %s: grant to row %0d col %0d with nothing pending",
                         cur_test, grant_o.row, grant_o.col);
            end
            else
            begin
                check("grant row", exp_row, int'(grant_o.row));
                check("grant col", exp_col, int'(grant_o.col));
                model_pend[exp_row * LVL_COLS + exp_col] = 1'b0;
            end
            if (cur_burst && (last_gnt_cyc >= 0))
                check("grant spacing", 1, cycles - last_gnt_cyc);
            last_gnt_cyc = cycles;
        end
    end

    initial
    begin : watchdog
        while (cycles < TIMEOUT)
        begin
            @(posedge clk_i);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles, the arbiter never went idle", cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        reset_i    = 1'b1;
        req_i      = '0;
        model_pend = '0;
        build_table();
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        for (int t = 0; t < NTEST; t++)
            run_entry(t);
        wait_idle();
        cur_test = "grant_count";
        // Each pulse earns exactly one grant
        for (int i = 0; i < NREQ; i++)
            check($sformatf("requester %0d", i), pulse_cnt[i], grant_cnt[i]);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/lib_arbiter_pkg.sv
verilog/priority_arb.sv
verilog/request_latch.sv
verilog/column_arbiter.sv
verilog/row_arbiter.sv
verilog/grid_arbiter.sv
testbench/grid_arbiter_assert.sv
testbench/grid_arbiter_tb.sv
